// File: mem_unit.f
+incdir+verilog
verilog/mem_op_pkg.sv
verilog/mem_pkt_pkg.sv
verilog/data_array.sv
verilog/load_extract.sv
verilog/store_align.sv
verilog/mem_ctrl.sv
verilog/mem_unit.sv
verification/tb_mem_unit.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_mem_unit
FILELIST  = mem_unit.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(wildcard verilog/*.sv verilog/*.svh verification/*.sv)
PASS_MSG  = SIMULATION PASSED

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the golden file is read at run time from the project root.
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/mem_unit_golden.hex
// opcode addr data mask expected_response, all hex, one packet per line.
// stores expect zero, loads and atomics expect the extended old value.
03 000 0000000000000000 00 0000000000000000
03 1f8 0000000000000000 00 0000000000000000
04 0a5 0000000000000000 00 0000000000000000
0b 008 f1e2d3c4b5a69788 00 0000000000000000
03 008 0000000000000000 00 f1e2d3c4b5a69788
02 008 0000000000000000 00 ffffffffb5a69788
06 008 0000000000000000 00 00000000b5a69788
02 00c 0000000000000000 00 fffffffff1e2d3c4
06 00e 0000000000000000 00 00000000f1e2d3c4
01 00a 0000000000000000 00 ffffffffffffb5a6
05 00a 0000000000000000 00 000000000000b5a6
01 00f 0000000000000000 00 fffffffffffff1e2
00 009 0000000000000000 00 ffffffffffffff97
04 009 0000000000000000 00 0000000000000097
00 00d 0000000000000000 00 ffffffffffffffd3
04 00f 0000000000000000 00 00000000000000f1
0b 010 1122334455667788 00 0000000000000000
0a 014 12345678aabbccdd 00 0000000000000000
03 010 0000000000000000 00 aabbccdd55667788
09 012 deadbeef0000eeff 00 0000000000000000
08 017 123456789abcde99 00 0000000000000000
0c 010 0102030405060708 21 0000000000000000
03 010 0000000000000000 00 99bb03ddeeff7708
10 01c 0000000080000005 00 0000000000000000
11 01c ffffffff00000010 00 ffffffff80000005
12 01c 00000000000000ff 00 ffffffff80000015
13 01c 000000008000000f 00 ffffffff800000ea
14 01c 0000000000000700 00 ffffffff8000000a
15 01c 0000000000000003 00 ffffffff8000070a
17 01c 0000000000000003 00 ffffffff8000070a
16 01c 00000000fffffff0 00 0000000000000003
18 01c 00000000fffffff0 00 0000000000000003
03 018 0000000000000000 00 fffffff000000000
20 020 8000000000000100 00 0000000000000000
21 020 00000000000000ff 00 8000000000000100
22 020 0f0000000000000f 00 80000000000001ff
23 020 ff000000000000f0 00 8f000000000001f0
24 020 0000000000000a00 00 8f000000000000f0
25 020 0000000000000001 00 8f00000000000af0
27 020 0000000000000001 00 8f00000000000af0
26 020 ffffffffffffff00 00 0000000000000001
28 020 ffffffffffffff00 00 0000000000000001
03 020 0000000000000000 00 ffffffffffffff00
0b 028 0000000000000001 00 0000000000000000
21 028 0000000000000001 00 0000000000000001
21 028 0000000000000001 00 0000000000000002
08 028 00000000000000ff 00 0000000000000000
03 028 0000000000000000 00 00000000000000ff
00 028 0000000000000000 00 ffffffffffffffff

// File: verification/tb_mem_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_unit_defs.svh"

module tb_mem_unit;

  localparam int    CLK_PERIOD   = 8;
  localparam int    RESET_CYCLES = 10;
  localparam int    DRIVE_DELAY  = 1;
  localparam        SEED         = 32'h8255ff56;
  localparam string GOLDEN_FILE  = "verification/mem_unit_golden.hex";

  logic                       clk_i = 1'b0;
  logic                       reset_i;
  mem_pkt_pkg::mem_req_s      req_i;
  logic                       v_i;
  logic                       ready_o;
  mem_pkt_pkg::mem_rsp_s      rsp_o;
  logic                       v_o;
  logic                       yumi_i;

  mem_pkt_pkg::mem_req_s      pkt_q[$];
  logic [`MEM_DATA_WIDTH-1:0] golden_q[$];
  logic [`MEM_DATA_WIDTH-1:0] expect_q[$];
  int                         next_idx    = 0;
  int                         cycle_count = 0;
  int                         cycle_limit = 100;
  logic [31:0]                rand_word;

  mem_unit uut (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (req_i),
    .v_i     (v_i),
    .ready_o (ready_o),
    .rsp_o   (rsp_o),
    .v_o     (v_o),
    .yumi_i  (yumi_i)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      abort_run("Value check failed.");
    end
  endtask

  task automatic load_golden();
    int                    fd;
    int                    fields;
    string                 line;
    logic [5:0]            op;
    logic [8:0]            addr;
    logic [63:0]           data;
    logic [7:0]            mask;
    logic [63:0]           rsp;
    mem_pkt_pkg::mem_req_s pkt;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      abort_run("Could not open the golden file.");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.substr(0, 1) != "//") begin
          fields = $sscanf(line, "%h %h %h %h %h", op, addr, data, mask, rsp);
          if (fields == 5) begin
            pkt.opcode = mem_op_pkg::mem_opcode_e'(op);
            pkt.addr   = addr;
            pkt.data   = data;
            pkt.mask   = mask;
            pkt_q.push_back(pkt);
            golden_q.push_back(rsp);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // v_i stays up with the same packet until it is taken.
  task automatic drive_inputs();
    if (next_idx < pkt_q.size()) begin
      v_i   = 1'b1;
      req_i = pkt_q[next_idx];
    end else begin
      v_i   = 1'b0;
      req_i = '0;
    end
    rand_word = $urandom;
    yumi_i    = v_o & rand_word[0];
  endtask

  task automatic track_handshakes();
    logic [63:0] expected;
    if (v_o && yumi_i) begin
      if (expect_q.size() == 0) begin
        abort_run("A response arrived with no packet outstanding.");
      end
      expected = expect_q.pop_front();
      check_value("rsp_o.data", expected, rsp_o.data);
    end
    if (v_i && ready_o) begin
      expect_q.push_back(golden_q[next_idx]);
      next_idx++;
    end
  endtask

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
      abort_run("Simulation stopped by the cycle limit.");
    end
  end

  initial begin
    rand_word = $urandom(SEED);
    reset_i   = 1'b1;
    v_i       = 1'b0;
    yumi_i    = 1'b0;
    req_i     = '0;
    load_golden();
    if (pkt_q.size() == 0) begin
      abort_run("The golden file holds no packets.");
    end
    cycle_limit = 4 * pkt_q.size() + 100; // reset fits in the fixed margin.

    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY reset_i = 1'b0;
    @(negedge clk_i);
    check_value("v_o", 64'd0, {63'd0, v_o});
    check_value("ready_o", 64'd1, {63'd0, ready_o});

    while (next_idx < pkt_q.size() || expect_q.size() > 0) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      drive_inputs();
      @(negedge clk_i);
      track_handshakes();
    end

    @(posedge clk_i);
    #DRIVE_DELAY;
    v_i    = 1'b0;
    yumi_i = 1'b0;
    @(negedge clk_i);
    check_value("v_o", 64'd0, {63'd0, v_o}); // a stray extra response would show here.

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/mem_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_unit_defs.svh"

module mem_unit (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  mem_pkt_pkg::mem_req_s req_i,
  input  logic                  v_i,
  output logic                  ready_o,
  output mem_pkt_pkg::mem_rsp_s rsp_o,
  output logic                  v_o,
  input  logic                  yumi_i
);

  logic [`MEM_ADDR_WIDTH-4:0] word_idx;
  logic [2:0]                 byte_off;
  logic [`MEM_DATA_WIDTH-1:0] rd_data;
  logic [`MEM_DATA_WIDTH-1:0] load_value;
  logic [`MEM_DATA_WIDTH-1:0] wr_data;
  logic [`MEM_MASK_WIDTH-1:0] wr_mask;
  logic                       is_write;
  logic                       wr_en;

  assign word_idx = req_i.addr[`MEM_ADDR_WIDTH-1:3];
  assign byte_off = req_i.addr[2:0];

  mem_ctrl ctrl (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .v_i          (v_i),
    .ready_o      (ready_o),
    .yumi_i       (yumi_i),
    .v_o          (v_o),
    .load_value_i (load_value),
    .is_write_i   (is_write),
    .wr_en_o      (wr_en),
    .rsp_o        (rsp_o)
  );

  data_array array (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .word_idx_i (word_idx),
    .wr_en_i    (wr_en),
    .wr_data_i  (wr_data),
    .wr_mask_i  (wr_mask),
    .rd_data_o  (rd_data)
  );

  load_extract extract (
    .opcode_i     (req_i.opcode),
    .byte_off_i   (byte_off),
    .rd_data_i    (rd_data),
    .load_value_o (load_value)
  );

  store_align align (
    .req_i        (req_i),
    .load_value_i (load_value),
    .wr_data_o    (wr_data),
    .wr_mask_o    (wr_mask),
    .is_write_o   (is_write)
  );

endmodule

`default_nettype wire

// File: verilog/mem_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_unit_defs.svh"

module mem_ctrl (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       v_i,
  output logic                       ready_o,
  input  logic                       yumi_i,
  output logic                       v_o,
  input  logic [`MEM_DATA_WIDTH-1:0] load_value_i,
  input  logic                       is_write_i,
  output logic                       wr_en_o,
  output mem_pkt_pkg::mem_rsp_s      rsp_o
);

  logic                  v_r;
  logic                  accept;
  mem_pkt_pkg::mem_rsp_s rsp_r;

  // the slot frees up in the same cycle the sink takes it.
  assign ready_o = ~v_r | yumi_i;
  assign accept  = v_i & ready_o;
  assign wr_en_o = accept & is_write_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
    end else if (ready_o) begin
      v_r <= v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_r.data <= load_value_i; // value read before the write lands.
    end
  end

  assign v_o   = v_r;
  assign rsp_o = rsp_r;

  // a stalled response must not change or vanish.
  assert property (@(posedge clk_i) disable iff (reset_i)
    v_o && !yumi_i |=> v_o && $stable(rsp_o));

  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o);

endmodule

`default_nettype wire

// File: verilog/store_align.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_unit_defs.svh"

module store_align (
  input  mem_pkt_pkg::mem_req_s      req_i,
  input  logic [`MEM_DATA_WIDTH-1:0] load_value_i,
  output logic [`MEM_DATA_WIDTH-1:0] wr_data_o,
  output logic [`MEM_MASK_WIDTH-1:0] wr_mask_o,
  output logic                       is_write_o
);

  mem_op_pkg::mem_size_e      size;
  logic                       masked;
  logic [`MEM_DATA_WIDTH-1:0] opnd;
  logic [`MEM_DATA_WIDTH-1:0] old;
  logic [31:0]                opnd_w;
  logic [31:0]                old_w;
  logic [`MEM_DATA_WIDTH-1:0] new_val;
  logic [2:0]                 off;

  assign opnd   = req_i.data;
  assign old    = load_value_i;
  assign opnd_w = opnd[31:0];
  assign old_w  = old[31:0];
  assign off    = req_i.addr[2:0];

  // W results only need to be right in the low 32 bits since the lanes are replicated below.
  always_comb begin
    case (req_i.opcode)
      mem_op_pkg::AMOADD_W:  new_val = {32'b0, opnd_w + old_w};
      mem_op_pkg::AMOADD_D:  new_val = opnd + old;
      mem_op_pkg::AMOXOR_W, mem_op_pkg::AMOXOR_D: new_val = opnd ^ old;
      mem_op_pkg::AMOAND_W, mem_op_pkg::AMOAND_D: new_val = opnd & old;
      mem_op_pkg::AMOOR_W, mem_op_pkg::AMOOR_D:   new_val = opnd | old;
      mem_op_pkg::AMOMIN_W:  new_val = ($signed(opnd_w) < $signed(old_w)) ? opnd : old;
      mem_op_pkg::AMOMIN_D:  new_val = ($signed(opnd) < $signed(old)) ? opnd : old;
      mem_op_pkg::AMOMAX_W:  new_val = ($signed(opnd_w) > $signed(old_w)) ? opnd : old;
      mem_op_pkg::AMOMAX_D:  new_val = ($signed(opnd) > $signed(old)) ? opnd : old;
      mem_op_pkg::AMOMINU_W: new_val = (opnd_w < old_w) ? opnd : old;
      mem_op_pkg::AMOMINU_D: new_val = (opnd < old) ? opnd : old;
      mem_op_pkg::AMOMAXU_W: new_val = (opnd_w > old_w) ? opnd : old;
      mem_op_pkg::AMOMAXU_D: new_val = (opnd > old) ? opnd : old;
      default:               new_val = opnd; // plain stores and swaps.
    endcase
  end

  always_comb begin
    size       = mem_op_pkg::SIZE_D;
    masked     = 1'b0;
    is_write_o = 1'b1;
    case (req_i.opcode)
      mem_op_pkg::SB: size = mem_op_pkg::SIZE_B;
      mem_op_pkg::SH: size = mem_op_pkg::SIZE_H;
      mem_op_pkg::SW, mem_op_pkg::AMOSWAP_W, mem_op_pkg::AMOADD_W,
      mem_op_pkg::AMOXOR_W, mem_op_pkg::AMOAND_W, mem_op_pkg::AMOOR_W,
      mem_op_pkg::AMOMIN_W, mem_op_pkg::AMOMAX_W, mem_op_pkg::AMOMINU_W,
      mem_op_pkg::AMOMAXU_W: size = mem_op_pkg::SIZE_W;
      mem_op_pkg::SD, mem_op_pkg::AMOSWAP_D, mem_op_pkg::AMOADD_D,
      mem_op_pkg::AMOXOR_D, mem_op_pkg::AMOAND_D, mem_op_pkg::AMOOR_D,
      mem_op_pkg::AMOMIN_D, mem_op_pkg::AMOMAX_D, mem_op_pkg::AMOMINU_D,
      mem_op_pkg::AMOMAXU_D: size = mem_op_pkg::SIZE_D;
      mem_op_pkg::SM: masked = 1'b1;
      default: is_write_o = 1'b0; // loads leave the row alone.
    endcase
  end

  always_comb begin
    if (!is_write_o) begin
      wr_data_o = '0;
      wr_mask_o = '0;
    end else if (masked) begin
      wr_data_o = new_val;
      wr_mask_o = req_i.mask;
    end else begin
      case (size)
        mem_op_pkg::SIZE_B: begin
          wr_data_o = {8{new_val[7:0]}};
          wr_mask_o = 8'b0000_0001 << off;
        end
        mem_op_pkg::SIZE_H: begin
          wr_data_o = {4{new_val[15:0]}};
          wr_mask_o = 8'b0000_0011 << {off[2:1], 1'b0};
        end
        mem_op_pkg::SIZE_W: begin
          wr_data_o = {2{new_val[31:0]}};
          wr_mask_o = 8'b0000_1111 << {off[2], 2'b00};
        end
        default: begin
          wr_data_o = new_val;
          wr_mask_o = '1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/load_extract.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_unit_defs.svh"

module load_extract (
  input  mem_op_pkg::mem_opcode_e    opcode_i,
  input  logic [2:0]                 byte_off_i,
  input  logic [`MEM_DATA_WIDTH-1:0] rd_data_i,
  output logic [`MEM_DATA_WIDTH-1:0] load_value_o
);

  mem_op_pkg::mem_size_e size;
  logic                  sign_ext;
  logic                  returns_data;
  logic [7:0]            byte_sel;
  logic [15:0]           half_sel;
  logic [31:0]           word_sel;

  // low offset bits below the access size drop out of the lane index.
  assign byte_sel = rd_data_i[{byte_off_i, 3'b000} +: 8];
  assign half_sel = rd_data_i[{byte_off_i[2:1], 4'b0000} +: 16];
  assign word_sel = rd_data_i[{byte_off_i[2], 5'b00000} +: 32];

  always_comb begin
    size         = mem_op_pkg::SIZE_D;
    sign_ext     = 1'b0;
    returns_data = 1'b1;
    case (opcode_i)
      mem_op_pkg::LB: begin
        size     = mem_op_pkg::SIZE_B;
        sign_ext = 1'b1;
      end
      mem_op_pkg::LBU: size = mem_op_pkg::SIZE_B;
      mem_op_pkg::LH: begin
        size     = mem_op_pkg::SIZE_H;
        sign_ext = 1'b1;
      end
      mem_op_pkg::LHU: size = mem_op_pkg::SIZE_H;
      mem_op_pkg::LW, mem_op_pkg::AMOSWAP_W, mem_op_pkg::AMOADD_W,
      mem_op_pkg::AMOXOR_W, mem_op_pkg::AMOAND_W, mem_op_pkg::AMOOR_W,
      mem_op_pkg::AMOMIN_W, mem_op_pkg::AMOMAX_W, mem_op_pkg::AMOMINU_W,
      mem_op_pkg::AMOMAXU_W: begin
        size     = mem_op_pkg::SIZE_W;
        sign_ext = 1'b1;
      end
      mem_op_pkg::LWU: size = mem_op_pkg::SIZE_W;
      mem_op_pkg::LD, mem_op_pkg::AMOSWAP_D, mem_op_pkg::AMOADD_D,
      mem_op_pkg::AMOXOR_D, mem_op_pkg::AMOAND_D, mem_op_pkg::AMOOR_D,
      mem_op_pkg::AMOMIN_D, mem_op_pkg::AMOMAX_D, mem_op_pkg::AMOMINU_D,
      mem_op_pkg::AMOMAXU_D: size = mem_op_pkg::SIZE_D;
      default: returns_data = 1'b0; // stores respond with zero.
    endcase
  end

  always_comb begin
    if (!returns_data) begin
      load_value_o = '0;
    end else begin
      case (size)
        mem_op_pkg::SIZE_B: load_value_o = {{56{sign_ext & byte_sel[7]}}, byte_sel};
        mem_op_pkg::SIZE_H: load_value_o = {{48{sign_ext & half_sel[15]}}, half_sel};
        mem_op_pkg::SIZE_W: load_value_o = {{32{sign_ext & word_sel[31]}}, word_sel};
        default:            load_value_o = rd_data_i;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/data_array.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_unit_defs.svh"

module data_array (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic [`MEM_ADDR_WIDTH-4:0]  word_idx_i,
  input  logic                        wr_en_i,
  input  logic [`MEM_DATA_WIDTH-1:0]  wr_data_i,
  input  logic [`MEM_MASK_WIDTH-1:0]  wr_mask_i,
  output logic [`MEM_DATA_WIDTH-1:0]  rd_data_o
);

  logic [`MEM_DATA_WIDTH-1:0] mem_r [`MEM_WORDS];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `MEM_WORDS; i++) begin
        mem_r[i] <= '0;
      end
    end else if (wr_en_i) begin
      for (int b = 0; b < `MEM_MASK_WIDTH; b++) begin
        if (wr_mask_i[b]) begin
          mem_r[word_idx_i][8*b +: 8] <= wr_data_i[8*b +: 8];
        end
      end
    end
  end

  // read is combinational so the atomic sees the value before this edge.
  assign rd_data_o = mem_r[word_idx_i];

endmodule

`default_nettype wire

// File: verilog/mem_pkt_pkg.sv
`default_nettype none

`include "mem_unit_defs.svh"

package mem_pkt_pkg;

  // request packet as it arrives from the cache front end.
  typedef struct packed {
    mem_op_pkg::mem_opcode_e     opcode;
    logic [`MEM_ADDR_WIDTH-1:0]  addr;
    logic [`MEM_DATA_WIDTH-1:0]  data;
    logic [`MEM_MASK_WIDTH-1:0]  mask; // only read by SM.
  } mem_req_s;

  typedef struct packed {
    logic [`MEM_DATA_WIDTH-1:0] data;
  } mem_rsp_s;

endpackage

`default_nettype wire

// File: verilog/mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

  typedef enum logic [5:0] {
    LB        = 6'h00,
    LH        = 6'h01,
    LW        = 6'h02,
    LD        = 6'h03,
    LBU       = 6'h04,
    LHU       = 6'h05,
    LWU       = 6'h06,
    SB        = 6'h08,
    SH        = 6'h09,
    SW        = 6'h0a,
    SD        = 6'h0b,
    SM        = 6'h0c, // byte lanes come from the request mask.
    AMOSWAP_W = 6'h10,
    AMOADD_W  = 6'h11,
    AMOXOR_W  = 6'h12,
    AMOAND_W  = 6'h13,
    AMOOR_W   = 6'h14,
    AMOMIN_W  = 6'h15,
    AMOMAX_W  = 6'h16,
    AMOMINU_W = 6'h17,
    AMOMAXU_W = 6'h18,
    AMOSWAP_D = 6'h20,
    AMOADD_D  = 6'h21,
    AMOXOR_D  = 6'h22,
    AMOAND_D  = 6'h23,
    AMOOR_D   = 6'h24,
    AMOMIN_D  = 6'h25,
    AMOMAX_D  = 6'h26,
    AMOMINU_D = 6'h27,
    AMOMAXU_D = 6'h28
  } mem_opcode_e;

  typedef enum logic [1:0] {
    SIZE_B = 2'b00,
    SIZE_H = 2'b01,
    SIZE_W = 2'b10,
    SIZE_D = 2'b11
  } mem_size_e;

endpackage

`default_nettype wire

// File: verilog/mem_unit_defs.svh
`ifndef MEM_UNIT_DEFS_SVH
`define MEM_UNIT_DEFS_SVH

// one storage row holds a full data word.
`define MEM_DATA_WIDTH 64

// bits 8 to 3 select the row, bits 2 to 0 the byte.
`define MEM_ADDR_WIDTH 9

`define MEM_WORDS 64

`define MEM_MASK_WIDTH (`MEM_DATA_WIDTH / 8)

`endif
